//--- warp_sched_pkg.sv
/*
 * Warp scheduler package.
 * Sizes, per-warp types and the issue entry shared by the scheduler blocks.
 */
package warp_sched_pkg;

    // core geometry
    localparam int NUM_WARPS        = 4;
    localparam int NW_BITS          = 2;
    localparam int NUM_THREADS      = 4;

    // word address without the byte offset
    localparam int PC_BITS          = 30;

    localparam int NUM_BARRIERS     = 4;
    localparam int NB_BITS          = 2;
    localparam int NUM_BRANCH_PORTS = 2;

    // per-cycle issued and committed counts up to NUM_WARPS
    localparam int CNT_BITS         = 3;

    localparam int PENDING_BITS     = 11;
    localparam int CTR_BITS         = 32;

    typedef logic [NW_BITS-1:0]     wid_t;
    typedef logic [NUM_WARPS-1:0]   warp_mask_t;
    typedef logic [NUM_THREADS-1:0] tmask_t;
    typedef logic [PC_BITS-1:0]     pc_t;
    typedef logic [NB_BITS-1:0]     bar_id_t;
    typedef logic [CNT_BITS-1:0]    cnt_t;
    typedef logic [CTR_BITS-1:0]    ctr_t;

    // one issued instruction slot toward fetch
    typedef struct packed {
        wid_t   wid;
        tmask_t tmask;
        pc_t    pc;
    } sched_entry_t;

endpackage

//--- warp_state.sv
/*
 * Warp state.
 * Per-warp active, stall, thread-mask and pc registers and the events that change them.
 */
`timescale 1ns/1ns

module warp_state (
    input  logic                                                  clk,
    input  logic                                                  reset,
    input  warp_sched_pkg::pc_t                                   start_pc,
    input  logic                                                  unlock_valid,
    input  warp_sched_pkg::wid_t                                  unlock_wid,
    input  logic                                                  ctl_valid,
    input  warp_sched_pkg::wid_t                                  ctl_wid,
    input  logic                                                  tmc_valid,
    input  warp_sched_pkg::tmask_t                                tmc_mask,
    input  logic                                                  wspawn_valid,
    input  warp_sched_pkg::warp_mask_t                            wspawn_mask,
    input  warp_sched_pkg::pc_t                                   wspawn_pc,
    input  logic [warp_sched_pkg::NUM_BRANCH_PORTS-1:0]           br_valid,
    input  warp_sched_pkg::wid_t [warp_sched_pkg::NUM_BRANCH_PORTS-1:0] br_wid,
    input  logic [warp_sched_pkg::NUM_BRANCH_PORTS-1:0]           br_taken,
    input  warp_sched_pkg::pc_t [warp_sched_pkg::NUM_BRANCH_PORTS-1:0]  br_dest,
    input  warp_sched_pkg::warp_mask_t                            bar_release,
    input  logic                                                  bar_arrive,
    input  logic                                                  accept_valid,
    input  warp_sched_pkg::wid_t                                  accept_wid,
    input  logic                                                  out_fire,
    input  warp_sched_pkg::sched_entry_t                          out_entry,
    output warp_sched_pkg::warp_mask_t                            ready_warps,
    output warp_sched_pkg::warp_mask_t                            active_warps,
    output warp_sched_pkg::tmask_t [warp_sched_pkg::NUM_WARPS-1:0] thread_masks,
    output warp_sched_pkg::pc_t [warp_sched_pkg::NUM_WARPS-1:0]    warp_pcs
);
    import warp_sched_pkg::*;

    warp_mask_t                  active_n;
    warp_mask_t                  stalled_warps;
    warp_mask_t                  stalled_n;
    tmask_t [NUM_WARPS-1:0]      tmasks_n;
    pc_t [NUM_WARPS-1:0]         pcs_n;

    // spawn request waits here until only one warp is left running
    logic                        spawn_pend;
    warp_mask_t                  spawn_mask;
    pc_t                         spawn_pc;
    wid_t                        spawn_wid;
    logic                        single_warp;
    logic                        spawn_fire;

    assign spawn_fire  = spawn_pend && single_warp;
    assign ready_warps = active_warps & ~stalled_warps;

    always_comb begin
        active_n  = active_warps;
        stalled_n = stalled_warps;
        tmasks_n  = thread_masks;
        pcs_n     = warp_pcs;

        // decode unlock
        if (unlock_valid) begin
            stalled_n[unlock_wid] = 1'b0;
        end

        // spawned warps start with thread 0 only
        if (spawn_fire) begin
            active_n = active_n | spawn_mask;
            for (int i = 0; i < NUM_WARPS; i++) begin
                if (spawn_mask[i]) begin
                    tmasks_n[i] = tmask_t'(1);
                    pcs_n[i]    = spawn_pc;
                end
            end
            stalled_n[spawn_wid] = 1'b0;
        end

        // zero mask retires the warp
        if (ctl_valid && tmc_valid) begin
            active_n[ctl_wid]  = (tmc_mask != '0);
            tmasks_n[ctl_wid]  = tmc_mask;
            stalled_n[ctl_wid] = 1'b0;
        end

        for (int i = 0; i < NUM_BRANCH_PORTS; i++) begin
            if (br_valid[i]) begin
                if (br_taken[i]) begin
                    pcs_n[br_wid[i]] = br_dest[i];
                end
                stalled_n[br_wid[i]] = 1'b0;
            end
        end

        // released waiters resume while a new arrival keeps waiting
        stalled_n = stalled_n & ~bar_release;
        if (bar_arrive) begin
            stalled_n[ctl_wid] = 1'b1;
        end

        // one instruction in flight per warp
        if (accept_valid) begin
            stalled_n[accept_wid] = 1'b1;
        end

        if (out_fire) begin
            pcs_n[out_entry.wid] = out_entry.pc + pc_t'(1);
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            active_warps    <= warp_mask_t'(1);
            stalled_warps   <= '0;
            thread_masks    <= '0;
            thread_masks[0] <= tmask_t'(1);
            warp_pcs        <= '0;
            warp_pcs[0]     <= start_pc;
            spawn_pend      <= 1'b0;
            single_warp     <= 1'b1;
        end else begin
            active_warps  <= active_n;
            stalled_warps <= stalled_n;
            thread_masks  <= tmasks_n;
            warp_pcs      <= pcs_n;
            single_warp   <= (active_warps != '0)
                          && ((active_warps & (active_warps - warp_mask_t'(1))) == '0);
            if (spawn_fire) begin
                spawn_pend <= 1'b0;
            end
            if (ctl_valid && wspawn_valid) begin
                spawn_pend <= 1'b1;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (ctl_valid && wspawn_valid) begin
            spawn_mask <= wspawn_mask;
            spawn_pc   <= wspawn_pc;
            spawn_wid  <= ctl_wid;
        end
    end

endmodule

//--- barrier_unit.sv
/*
 * Barrier unit.
 * Counts arrivals at the local synchronous barriers and reports which warps to release.
 */
`timescale 1ns/1ns

module barrier_unit (
    input  logic                       clk,
    input  logic                       reset,
    input  logic                       bar_valid,
    input  warp_sched_pkg::wid_t       bar_wid,
    input  warp_sched_pkg::bar_id_t    bar_id,
    input  warp_sched_pkg::wid_t       bar_size_m1,
    output warp_sched_pkg::warp_mask_t bar_release,
    output logic                       bar_arrive
);
    import warp_sched_pkg::*;

    // arrivals so far and the warps parked on each barrier
    wid_t [NUM_BARRIERS-1:0]       bar_ctrs;
    warp_mask_t [NUM_BARRIERS-1:0] bar_masks;

    warp_mask_t                    arrive_mask;
    logic                          last_arrival;

    always_comb begin
        arrive_mask          = bar_masks[bar_id];
        arrive_mask[bar_wid] = 1'b1;
        last_arrival         = bar_valid && (bar_ctrs[bar_id] == bar_size_m1);
    end

    // the last warp in releases everyone including itself
    assign bar_release = last_arrival ? arrive_mask : '0;
    assign bar_arrive  = bar_valid && !last_arrival;

    always_ff @(posedge clk) begin
        if (reset) begin
            bar_ctrs  <= '0;
            bar_masks <= '0;
        end else if (bar_valid) begin
            if (last_arrival) begin
                bar_ctrs[bar_id]  <= '0;
                bar_masks[bar_id] <= '0;
            end else begin
                bar_ctrs[bar_id]  <= bar_ctrs[bar_id] + wid_t'(1);
                bar_masks[bar_id] <= arrive_mask;
            end
        end
    end

endmodule

//--- warp_select.sv
/*
 * Warp select.
 * Picks the lowest-index ready warp and forms its issue entry.
 */
`timescale 1ns/1ns

module warp_select (
    input  warp_sched_pkg::warp_mask_t                             ready_warps,
    input  warp_sched_pkg::tmask_t [warp_sched_pkg::NUM_WARPS-1:0] thread_masks,
    input  warp_sched_pkg::pc_t [warp_sched_pkg::NUM_WARPS-1:0]    warp_pcs,
    output logic                                                   cand_valid,
    output warp_sched_pkg::sched_entry_t                           cand_entry
);
    import warp_sched_pkg::*;

    wid_t sel_wid;

    // scan downward so the lowest ready index is the one left standing
    always_comb begin
        sel_wid = '0;
        for (int i = NUM_WARPS - 1; i >= 0; i--) begin
            if (ready_warps[i]) begin
                sel_wid = wid_t'(i);
            end
        end
    end

    assign cand_valid       = (ready_warps != '0);
    assign cand_entry.wid   = sel_wid;
    assign cand_entry.tmask = thread_masks[sel_wid];
    assign cand_entry.pc    = warp_pcs[sel_wid];

endmodule

//--- issue_buffer.sv
/*
 * Issue buffer.
 * Two-entry skid buffer with a registered output stage toward fetch.
 */
`timescale 1ns/1ns

module issue_buffer (
    input  logic                         clk,
    input  logic                         reset,
    input  logic                         in_valid,
    input  warp_sched_pkg::sched_entry_t in_entry,
    output logic                         in_ready,
    output logic                         out_valid,
    output warp_sched_pkg::sched_entry_t out_entry,
    input  logic                         out_ready
);
    import warp_sched_pkg::*;

    logic         skid_valid;
    sched_entry_t skid_entry;
    logic         out_load;

    // ready depends on local state only and not on out_ready
    assign in_ready = ~skid_valid;
    assign out_load = ~out_valid || out_ready;

    always_ff @(posedge clk) begin
        if (reset) begin
            out_valid  <= 1'b0;
            skid_valid <= 1'b0;
        end else if (out_load) begin
            // older skid entry goes first
            if (skid_valid) begin
                out_valid  <= 1'b1;
                skid_valid <= 1'b0;
            end else begin
                out_valid <= in_valid;
            end
        end else if (in_valid && in_ready) begin
            skid_valid <= 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        if (out_load) begin
            if (skid_valid) begin
                out_entry <= skid_entry;
            end else if (in_valid) begin
                out_entry <= in_entry;
            end
        end
        if (!out_load && in_valid && in_ready) begin
            skid_entry <= in_entry;
        end
    end

endmodule

//--- sched_counters.sv
/*
 * Scheduler counters.
 * Cycle, retired-instruction and pending-instruction counts, plus the busy flag.
 */
`timescale 1ns/1ns

module sched_counters (
    input  logic                       clk,
    input  logic                       reset,
    input  warp_sched_pkg::cnt_t       issued_cnt,
    input  warp_sched_pkg::cnt_t       committed_cnt,
    input  warp_sched_pkg::warp_mask_t active_warps,
    output warp_sched_pkg::ctr_t       cycles,
    output warp_sched_pkg::ctr_t       instret,
    output logic                       busy
);
    import warp_sched_pkg::*;

    logic [PENDING_BITS-1:0] pending;
    logic [PENDING_BITS-1:0] pending_n;

    // instructions issued but not yet committed
    assign pending_n = pending + PENDING_BITS'(issued_cnt) - PENDING_BITS'(committed_cnt);

    always_ff @(posedge clk) begin
        if (reset) begin
            pending <= '0;
        end else begin
            pending <= pending_n;
        end
    end

    // busy starts high since warp 0 comes out of reset active
    always_ff @(posedge clk) begin
        if (reset) begin
            busy <= 1'b1;
        end else begin
            busy <= (active_warps != '0) || (pending_n != '0);
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            cycles  <= '0;
            instret <= '0;
        end else begin
            if (busy) begin
                cycles <= cycles + ctr_t'(1);
            end
            instret <= instret + ctr_t'(committed_cnt);
        end
    end

endmodule

//--- warp_scheduler.sv
/*
 * Warp scheduler top.
 * Connects warp state, barriers, warp selection, the issue buffer and the counters.
 */
`timescale 1ns/1ns

module warp_scheduler (
    input  logic                                                   clk,
    input  logic                                                   reset,
    input  warp_sched_pkg::pc_t                                    start_pc,
    input  logic                                                   unlock_valid,
    input  warp_sched_pkg::wid_t                                   unlock_wid,
    input  logic                                                   ctl_valid,
    input  warp_sched_pkg::wid_t                                   ctl_wid,
    input  logic                                                   tmc_valid,
    input  warp_sched_pkg::tmask_t                                 tmc_mask,
    input  logic                                                   wspawn_valid,
    input  warp_sched_pkg::warp_mask_t                             wspawn_mask,
    input  warp_sched_pkg::pc_t                                    wspawn_pc,
    input  logic                                                   bar_valid,
    input  warp_sched_pkg::bar_id_t                                bar_id,
    input  warp_sched_pkg::wid_t                                   bar_size_m1,
    input  logic [warp_sched_pkg::NUM_BRANCH_PORTS-1:0]            br_valid,
    input  warp_sched_pkg::wid_t [warp_sched_pkg::NUM_BRANCH_PORTS-1:0] br_wid,
    input  logic [warp_sched_pkg::NUM_BRANCH_PORTS-1:0]            br_taken,
    input  warp_sched_pkg::pc_t [warp_sched_pkg::NUM_BRANCH_PORTS-1:0]  br_dest,
    input  warp_sched_pkg::cnt_t                                   issued_cnt,
    input  warp_sched_pkg::cnt_t                                   committed_cnt,
    input  logic                                                   sched_ready,
    output logic                                                   sched_valid,
    output warp_sched_pkg::sched_entry_t                           sched_entry,
    output warp_sched_pkg::ctr_t                                   cycles,
    output warp_sched_pkg::ctr_t                                   instret,
    output warp_sched_pkg::warp_mask_t                             active_warps,
    output warp_sched_pkg::tmask_t [warp_sched_pkg::NUM_WARPS-1:0] thread_masks,
    output logic                                                   busy
);
    import warp_sched_pkg::*;

    warp_mask_t             ready_warps;
    pc_t [NUM_WARPS-1:0]    warp_pcs;
    warp_mask_t             bar_release;
    logic                   bar_arrive;
    logic                   cand_valid;
    sched_entry_t           cand_entry;
    logic                   buf_ready;
    logic                   accept;
    logic                   out_fire;

    assign accept   = cand_valid && buf_ready;
    assign out_fire = sched_valid && sched_ready;

    warp_state warp_state_inst (
        .clk          (clk),
        .reset        (reset),
        .start_pc     (start_pc),
        .unlock_valid (unlock_valid),
        .unlock_wid   (unlock_wid),
        .ctl_valid    (ctl_valid),
        .ctl_wid      (ctl_wid),
        .tmc_valid    (tmc_valid),
        .tmc_mask     (tmc_mask),
        .wspawn_valid (wspawn_valid),
        .wspawn_mask  (wspawn_mask),
        .wspawn_pc    (wspawn_pc),
        .br_valid     (br_valid),
        .br_wid       (br_wid),
        .br_taken     (br_taken),
        .br_dest      (br_dest),
        .bar_release  (bar_release),
        .bar_arrive   (bar_arrive),
        .accept_valid (accept),
        .accept_wid   (cand_entry.wid),
        .out_fire     (out_fire),
        .out_entry    (sched_entry),
        .ready_warps  (ready_warps),
        .active_warps (active_warps),
        .thread_masks (thread_masks),
        .warp_pcs     (warp_pcs)
    );

    // barrier strobe rides on the warp-control strobe
    barrier_unit barrier_unit_inst (
        .clk         (clk),
        .reset       (reset),
        .bar_valid   (ctl_valid && bar_valid),
        .bar_wid     (ctl_wid),
        .bar_id      (bar_id),
        .bar_size_m1 (bar_size_m1),
        .bar_release (bar_release),
        .bar_arrive  (bar_arrive)
    );

    warp_select warp_select_inst (
        .ready_warps  (ready_warps),
        .thread_masks (thread_masks),
        .warp_pcs     (warp_pcs),
        .cand_valid   (cand_valid),
        .cand_entry   (cand_entry)
    );

    issue_buffer issue_buffer_inst (
        .clk       (clk),
        .reset     (reset),
        .in_valid  (cand_valid),
        .in_entry  (cand_entry),
        .in_ready  (buf_ready),
        .out_valid (sched_valid),
        .out_entry (sched_entry),
        .out_ready (sched_ready)
    );

    sched_counters sched_counters_inst (
        .clk           (clk),
        .reset         (reset),
        .issued_cnt    (issued_cnt),
        .committed_cnt (committed_cnt),
        .active_warps  (active_warps),
        .cycles        (cycles),
        .instret       (instret),
        .busy          (busy)
    );

endmodule

//--- tb_clock_gen.sv
/*
 * Testbench clock and reset.
 * 4 ns clock with reset held high for the first 4 cycles.
 */
`timescale 1ns/1ns

module tb_clock_gen (
    output logic clk,
    output logic reset
);

    initial begin
        clk = 1'b0;
        forever #2 clk = ~clk;
    end

    initial begin
        reset = 1'b1;
        repeat (4) @(posedge clk);
        reset <= 1'b0;
    end

endmodule

//--- tb_warp_scheduler.sv
/*
 * Warp scheduler testbench.
 * Directed tests of unlock, TMC, spawn, branch, barrier and back-pressure behavior.
 */
`timescale 1ns/1ns

module tb_warp_scheduler;
    import warp_sched_pkg::*;

    localparam int TIMEOUT    = 200;
    localparam int QUIET_CYCS = 10;

    logic                        clk;
    logic                        reset;
    pc_t                         start_pc;
    logic                        unlock_valid;
    wid_t                        unlock_wid;
    logic                        ctl_valid;
    wid_t                        ctl_wid;
    logic                        tmc_valid;
    tmask_t                      tmc_mask;
    logic                        wspawn_valid;
    warp_mask_t                  wspawn_mask;
    pc_t                         wspawn_pc;
    logic                        bar_valid;
    bar_id_t                     bar_id;
    wid_t                        bar_size_m1;
    logic [NUM_BRANCH_PORTS-1:0] br_valid;
    wid_t [NUM_BRANCH_PORTS-1:0] br_wid;
    logic [NUM_BRANCH_PORTS-1:0] br_taken;
    pc_t [NUM_BRANCH_PORTS-1:0]  br_dest;
    cnt_t                        issued_cnt;
    cnt_t                        committed_cnt;
    logic                        sched_ready;
    logic                        sched_valid;
    sched_entry_t                sched_entry;
    ctr_t                        cycles;
    ctr_t                        instret;
    warp_mask_t                  active_warps;
    tmask_t [NUM_WARPS-1:0]      thread_masks;
    logic                        busy;

    // reference copy of each warp's pc and thread mask
    pc_t          model_pc [NUM_WARPS];
    tmask_t       model_mask [NUM_WARPS];
    sched_entry_t entry_q [$];
    ctr_t         xfer_count;
    ctr_t         committed_total;
    logic [31:0]  lcg_state;
    int           error_count;
    int           check_count;

    tb_clock_gen tb_clock_gen_inst (
        .clk   (clk),
        .reset (reset)
    );

    warp_scheduler warp_scheduler_inst (
        .clk           (clk),
        .reset         (reset),
        .start_pc      (start_pc),
        .unlock_valid  (unlock_valid),
        .unlock_wid    (unlock_wid),
        .ctl_valid     (ctl_valid),
        .ctl_wid       (ctl_wid),
        .tmc_valid     (tmc_valid),
        .tmc_mask      (tmc_mask),
        .wspawn_valid  (wspawn_valid),
        .wspawn_mask   (wspawn_mask),
        .wspawn_pc     (wspawn_pc),
        .bar_valid     (bar_valid),
        .bar_id        (bar_id),
        .bar_size_m1   (bar_size_m1),
        .br_valid      (br_valid),
        .br_wid        (br_wid),
        .br_taken      (br_taken),
        .br_dest       (br_dest),
        .issued_cnt    (issued_cnt),
        .committed_cnt (committed_cnt),
        .sched_ready   (sched_ready),
        .sched_valid   (sched_valid),
        .sched_entry   (sched_entry),
        .cycles        (cycles),
        .instret       (instret),
        .active_warps  (active_warps),
        .thread_masks  (thread_masks),
        .busy          (busy)
    );

    // every output transfer lands in the queue in order
    always @(posedge clk) begin
        if (!reset && sched_valid && sched_ready) begin
            entry_q.push_back(sched_entry);
            xfer_count = xfer_count + ctr_t'(1);
        end
    end

    function automatic logic [31:0] lcg_next();
        lcg_state = lcg_state * 32'd1103515245 + 32'd12345;
        return lcg_state;
    endfunction

    function automatic sched_entry_t expected_entry(input int w);
        sched_entry_t e;
        e.wid   = wid_t'(w);
        e.tmask = model_mask[w];
        e.pc    = model_pc[w];
        return e;
    endfunction

    task automatic report_timeout(input string what);
        error_count++;
        $display("Timeout at %0t ns: %s", $time, what);
        $display("%0d checks, %0d errors", check_count, error_count);
        $display("Simulation failed");
        $finish;
    endtask

    task automatic check_entry(input string name, input sched_entry_t got,
                               input sched_entry_t exp);
        check_count++;
        if (got !== exp) begin
            error_count++;
            $write("** Error at %0t ns: %s expected wid %0d tmask %b pc %h,",
                   $time, name, exp.wid, exp.tmask, exp.pc);
            $display(" got wid %0d tmask %b pc %h", got.wid, got.tmask, got.pc);
        end
    endtask

    task automatic check_ctr(input string name, input ctr_t got, input ctr_t exp);
        check_count++;
        if (got !== exp) begin
            error_count++;
            $display("** Error at %0t ns: %s expected %0d got %0d", $time, name, exp, got);
        end
    endtask

    task automatic check_mask(input string name, input warp_mask_t got,
                              input warp_mask_t exp);
        check_count++;
        if (got !== exp) begin
            error_count++;
            $display("** Error at %0t ns: %s expected %b got %b", $time, name, exp, got);
        end
    endtask

    task automatic check_tmask(input string name, input tmask_t got, input tmask_t exp);
        check_count++;
        if (got !== exp) begin
            error_count++;
            $display("** Error at %0t ns: %s expected %b got %b", $time, name, exp, got);
        end
    endtask

    task automatic check_flag(input string name, input logic got, input logic exp);
        check_count++;
        if (got !== exp) begin
            error_count++;
            $display("** Error at %0t ns: %s expected %b got %b", $time, name, exp, got);
        end
    endtask

    task automatic next_entry(output sched_entry_t e);
        int waited;
        e      = '0;
        waited = 0;
        while (entry_q.size() == 0 && waited < TIMEOUT) begin
            @(negedge clk);
            waited++;
        end
        if (entry_q.size() == 0) begin
            report_timeout("no entry transferred on the scheduler output");
        end else begin
            e = entry_q.pop_front();
        end
    endtask

    // the warp's pc moves one word once its entry has left
    task automatic expect_entry(input int w);
        sched_entry_t got;
        next_entry(got);
        check_entry("sched_entry", got, expected_entry(w));
        model_pc[w] = model_pc[w] + pc_t'(1);
    endtask

    task automatic idle_no_issue(input int n);
        repeat (n) @(negedge clk);
        check_ctr("transfers while stalled", ctr_t'(entry_q.size()), ctr_t'(0));
    endtask

    task automatic unlock_warp(input int w);
        @(posedge clk);
        unlock_valid <= 1'b1;
        unlock_wid   <= wid_t'(w);
        @(posedge clk);
        unlock_valid <= 1'b0;
    endtask

    task automatic set_thread_mask(input int w, input tmask_t mask);
        @(posedge clk);
        ctl_valid <= 1'b1;
        ctl_wid   <= wid_t'(w);
        tmc_valid <= 1'b1;
        tmc_mask  <= mask;
        @(posedge clk);
        ctl_valid <= 1'b0;
        tmc_valid <= 1'b0;
    endtask

    task automatic spawn_warps(input int w, input warp_mask_t mask, input pc_t pc);
        @(posedge clk);
        ctl_valid    <= 1'b1;
        ctl_wid      <= wid_t'(w);
        wspawn_valid <= 1'b1;
        wspawn_mask  <= mask;
        wspawn_pc    <= pc;
        @(posedge clk);
        ctl_valid    <= 1'b0;
        wspawn_valid <= 1'b0;
    endtask

    task automatic resolve_branch(input int port, input int w, input logic taken,
                                  input pc_t dest);
        @(posedge clk);
        br_valid[port] <= 1'b1;
        br_wid[port]   <= wid_t'(w);
        br_taken[port] <= taken;
        br_dest[port]  <= dest;
        @(posedge clk);
        br_valid <= '0;
    endtask

    task automatic arrive_barrier(input int w, input int id, input int size_m1);
        @(posedge clk);
        ctl_valid   <= 1'b1;
        ctl_wid     <= wid_t'(w);
        bar_valid   <= 1'b1;
        bar_id      <= bar_id_t'(id);
        bar_size_m1 <= wid_t'(size_m1);
        @(posedge clk);
        ctl_valid <= 1'b0;
        bar_valid <= 1'b0;
    endtask

    task automatic add_counts(input int issued, input int committed);
        @(posedge clk);
        issued_cnt      <= cnt_t'(issued);
        committed_cnt   <= cnt_t'(committed);
        committed_total = committed_total + ctr_t'(committed);
        @(posedge clk);
        issued_cnt    <= '0;
        committed_cnt <= '0;
    endtask

    task automatic reset_and_unlock_test();
        expect_entry(0);
        check_flag("busy", busy, 1'b1);
        idle_no_issue(QUIET_CYCS);
        unlock_warp(0);
        expect_entry(0);
    endtask

    task automatic tmc_test();
        int waited;
        set_thread_mask(0, 4'b1011);
        model_mask[0] = 4'b1011;
        expect_entry(0);
        check_tmask("thread_masks[0]", thread_masks[0], model_mask[0]);
        add_counts(3, 0);
        set_thread_mask(0, 4'b0000);
        model_mask[0] = 4'b0000;
        idle_no_issue(QUIET_CYCS);
        check_mask("active_warps", active_warps, warp_mask_t'(0));
        check_tmask("thread_masks[0]", thread_masks[0], model_mask[0]);
        check_flag("busy", busy, 1'b1);
        add_counts(0, 1);
        add_counts(0, 2);
        waited = 0;
        while (busy !== 1'b0 && waited < TIMEOUT) begin
            @(negedge clk);
            waited++;
        end
        if (busy !== 1'b0) begin
            report_timeout("busy stayed high after the counts balanced");
        end
        // nonzero mask brings warp 0 back at its current pc
        set_thread_mask(0, 4'b0001);
        model_mask[0] = 4'b0001;
        expect_entry(0);
    endtask

    task automatic spawn_test();
        pc_t spawn_pc;
        spawn_pc = pc_t'(lcg_next() >> 2);
        spawn_warps(0, 4'b1110, spawn_pc);
        for (int w = 1; w < NUM_WARPS; w++) begin
            model_pc[w]   = spawn_pc;
            model_mask[w] = 4'b0001;
        end
        // all four ready together so the lowest index goes first
        for (int w = 0; w < NUM_WARPS; w++) begin
            expect_entry(w);
        end
        check_mask("active_warps", active_warps, 4'b1111);
        for (int w = 0; w < NUM_WARPS; w++) begin
            check_tmask("thread_masks", thread_masks[w], model_mask[w]);
        end
    endtask

    task automatic branch_test();
        pc_t dest;
        dest = pc_t'(lcg_next() >> 2);
        resolve_branch(0, 1, 1'b1, dest);
        model_pc[1] = dest;
        expect_entry(1);
        resolve_branch(1, 2, 1'b0, pc_t'(lcg_next() >> 2));
        expect_entry(2);
        dest = pc_t'(lcg_next() >> 2);
        resolve_branch(1, 3, 1'b1, dest);
        model_pc[3] = dest;
        expect_entry(3);
        resolve_branch(0, 0, 1'b0, pc_t'(lcg_next() >> 2));
        expect_entry(0);
    endtask

    task automatic barrier_test();
        arrive_barrier(0, 1, 2);
        idle_no_issue(QUIET_CYCS);
        arrive_barrier(1, 1, 2);
        idle_no_issue(QUIET_CYCS);
        arrive_barrier(2, 1, 2);
        expect_entry(0);
        expect_entry(1);
        expect_entry(2);
        idle_no_issue(QUIET_CYCS);
    endtask

    task automatic backpressure_test();
        ctr_t         sent;
        sched_entry_t held;
        int           waited;
        sent = xfer_count;
        @(posedge clk);
        sched_ready <= 1'b0;
        // warp 3 fills the output stage and warp 1 the skid slot
        unlock_warp(3);
        unlock_warp(1);
        unlock_warp(2);
        unlock_warp(0);
        waited = 0;
        while (sched_valid !== 1'b1 && waited < TIMEOUT) begin
            @(negedge clk);
            waited++;
        end
        if (sched_valid !== 1'b1) begin
            report_timeout("sched_valid never rose under back-pressure");
        end
        held = sched_entry;
        check_entry("held sched_entry", held, expected_entry(3));
        repeat (QUIET_CYCS) begin
            @(negedge clk);
            check_entry("sched_entry under back-pressure", sched_entry, held);
            check_flag("sched_valid", sched_valid, 1'b1);
        end
        @(posedge clk);
        sched_ready <= 1'b1;
        // buffered entries drain before the waiting warps in index order
        expect_entry(3);
        expect_entry(1);
        expect_entry(0);
        expect_entry(2);
        add_counts(4, 4);
        repeat (2) @(negedge clk);
        // four unlocked warps give exactly four transfers
        check_ctr("transfer count", xfer_count, sent + ctr_t'(4));
        check_ctr("instret", instret, committed_total);
        check_count++;
        if (cycles == '0) begin
            error_count++;
            $display("Cycle counter stayed at zero although the scheduler was busy");
        end
    endtask

    initial begin
        int waited;
        error_count     = 0;
        check_count     = 0;
        xfer_count      = '0;
        committed_total = '0;
        lcg_state       = 32'd73674;
        start_pc        = pc_t'(lcg_next() >> 2);
        unlock_valid    = 1'b0;
        unlock_wid      = '0;
        ctl_valid       = 1'b0;
        ctl_wid         = '0;
        tmc_valid       = 1'b0;
        tmc_mask        = '0;
        wspawn_valid    = 1'b0;
        wspawn_mask     = '0;
        wspawn_pc       = '0;
        bar_valid       = 1'b0;
        bar_id          = '0;
        bar_size_m1     = '0;
        br_valid        = '0;
        br_wid          = '0;
        br_taken        = '0;
        br_dest         = '0;
        issued_cnt      = '0;
        committed_cnt   = '0;
        sched_ready     = 1'b1;
        for (int w = 0; w < NUM_WARPS; w++) begin
            model_pc[w]   = '0;
            model_mask[w] = '0;
        end
        model_pc[0]   = start_pc;
        model_mask[0] = 4'b0001;

        waited = 0;
        while (reset !== 1'b0 && waited < TIMEOUT) begin
            @(negedge clk);
            waited++;
        end
        if (reset !== 1'b0) begin
            report_timeout("reset was never released");
        end

        reset_and_unlock_test();
        tmc_test();
        spawn_test();
        branch_test();
        barrier_test();
        backpressure_test();

        $display("%0d checks, %0d errors", check_count, error_count);
        if (error_count == 0) begin
            $display("Simulation completed successfully");
        end else begin
            $display("Simulation failed");
        end
        $finish;
    end

endmodule

//--- verilog.f
warp_sched_pkg.sv
warp_state.sv
barrier_unit.sv
warp_select.sv
issue_buffer.sv
sched_counters.sv
warp_scheduler.sv
tb_clock_gen.sv
tb_warp_scheduler.sv
